// ==== Makefile ====
TOP       ?= tb_sort_top
FILELIST  ?= build.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
common/sort_pkg.sv
common/sort_load_if.sv
common/sort_read_if.sv
hw/sort_engine/sort_loader.sv
hw/sort_engine/sort_core.sv
hw/sort_engine/sort_unloader.sv
hw/sort_top.sv
dv/sort_properties.sv
dv/tb_sort_top.sv

// ==== common/sort_load_if.sv ====
interface sort_load_if #(
   parameter int nelems    = 5,
   parameter int word_size = 11
);

   localparam int idx_w = sort_pkg::idx_width(nelems);

   logic                 wr_en;   // one-cycle element write
   logic [idx_w-1:0]     wr_idx;
   logic [word_size-1:0] wr_data;
   logic                 start;   // pulse, one cycle after the last write
   logic                 busy;    // level, core owns the array

   modport loader
   (
      output wr_en,
      output wr_idx,
      output wr_data,
      output start,
      input  busy
   );

   modport core
   (
      input  wr_en,
      input  wr_idx,
      input  wr_data,
      input  start,
      output busy
   );

endinterface

// ==== common/sort_pkg.sv ====
package sort_pkg;

   // defaults picked up by sort_top
   localparam int default_nelems    = 5;
   localparam int default_word_size = 11;

   // headroom on the running sums so that nelems words never overflow
   localparam int sum_guard_bits = 6;

   // core control states
   typedef enum logic [1:0]
   {
      IDLE    = 2'd0,   // accepting element writes
      LOADED  = 2'd1,   // last element written, waiting on start
      SORTING = 2'd2,   // one bubble pass per clock
      DONE    = 2'd3    // sorted, unloader owns the array
   } core_state_e;

   // width of an element index
   function automatic int idx_width(int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

   // width of the input and output checksums
   function automatic int sum_width(int ws);
      return ws + sum_guard_bits;
   endfunction

endpackage

// ==== common/sort_read_if.sv ====
interface sort_read_if #(
   parameter int nelems    = 5,
   parameter int word_size = 11
);

   localparam int idx_w = sort_pkg::idx_width(nelems);

   logic                 done;         // level while the core sits in DONE
   logic [idx_w-1:0]     rd_idx;
   logic [word_size-1:0] rd_data;      // combinational read of the array
   logic                 blk_release;  // hands the array back to the core

   modport core
   (
      output done,
      input  rd_idx,
      output rd_data,
      input  blk_release
   );

   modport unloader
   (
      input  done,
      output rd_idx,
      input  rd_data,
      output blk_release
   );

endinterface

// ==== dv/sort_properties.sv ====
module sort_properties #(
   parameter int nelems    = 5,
   parameter int word_size = 11
)
(
   input logic                  clk,
   input logic                  rst_n,
   input logic                  busy,
   input logic                  out_valid,
   input logic [word_size-1:0]  out_data,
   input logic                  out_last,
   input logic                  sum_error,
   input logic                  start,
   input logic                  done,
   input logic                  blk_release,
   input sort_pkg::core_state_e state
);

   int vcnt;            // out_valid cycles so far in the frame
   int wait_cnt;        // cycles busy without done
   int fail_count = 0;  // watched from the testbench

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vcnt     <= 0;
         wait_cnt <= 0;
      end
      else
      begin
         vcnt     <= out_valid ? vcnt + 1 : 0;
         wait_cnt <= (busy && !done) ? wait_cnt + 1 : 0;
      end
   end

   task automatic flag(input string what);
      $error("%s", what);
      fail_count++;
   endtask

   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> !busy && !out_valid && !out_last && !sum_error)
      else flag("outputs active during or right after reset");
   ascending: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && $past(out_valid) && !$past(out_last) |-> out_data >= $past(out_data))
      else flag("output words not in ascending order");
   no_sum_error: assert property (@(posedge clk) disable iff (!rst_n) !sum_error)
      else flag("checksum mismatch raised");
   last_count: assert property (@(posedge clk) disable iff (!rst_n)
      out_last |-> out_valid && vcnt == nelems - 1)
      else flag("out_last not on the final word of a full frame");
   frame_length: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_last |-> vcnt < nelems - 1)
      else flag("frame longer than the block");
   start_with_busy: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> start)
      else flag("busy rose without a start pulse");
   start_sorts: assert property (@(posedge clk) disable iff (!rst_n)
      start |=> state == sort_pkg::SORTING)
      else flag("core did not enter SORTING after start");
   terminates: assert property (@(posedge clk) disable iff (!rst_n)
      busy && !done |-> wait_cnt <= nelems)
      else flag("sort took more than one pass per element");
   release_frees: assert property (@(posedge clk) disable iff (!rst_n)
      blk_release |=> !busy)
      else flag("busy still high the cycle after release");

endmodule

bind sort_top sort_properties #(
   .nelems    (nelems),
   .word_size (word_size)
) u_props (
   .clk         (clk),
   .rst_n       (rst_n),
   .busy        (busy),
   .out_valid   (out_valid),
   .out_data    (out_data),
   .out_last    (out_last),
   .sum_error   (sum_error),
   .start       (ld_if.start),
   .done        (rd_if.done),
   .blk_release (rd_if.blk_release),
   .state       (u_core.state)
);

// ==== dv/tb_sort_top.sv ====
module tb_sort_top;

   localparam int nelems     = 5;
   localparam int word_size  = 11;
   localparam int sort_limit = 4 * nelems;  // cycles from busy to out_valid

   typedef logic [word_size-1:0] word_t;

   logic  clk;
   logic  rst_n;
   logic  in_valid;
   word_t in_data;
   logic  busy;
   logic  out_valid;
   word_t out_data;
   logic  out_last;
   logic  sum_error;

   word_t blk [nelems];
   word_t exp_q [$];  // sorted model of the current block

   sort_top #(.nelems(nelems), .word_size(word_size)) u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .busy      (busy),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .sum_error (sum_error)
   );

   always #10 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input int expected, input int actual);
      assert (expected == actual)
      else abort_run($sformatf("FAILED %s: expected %0d, actual %0d", test, expected, actual));
   endtask

   // bound assertions count their failures
   always @(negedge clk)
   begin
      if (u_dut.u_props.fail_count != 0)
      begin
         abort_run("a bound property assertion failed");
      end
   end

   task automatic wait_busy(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (busy !== level && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (busy !== level)
      begin
         abort_run({what, ": timed out waiting for busy"});
      end
   endtask

   task automatic wait_out_valid(input int limit, input string what);
      int n;
      n = 0;
      while (out_valid !== 1'b1 && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (out_valid !== 1'b1)
      begin
         abort_run({what, ": timed out waiting for out_valid"});
      end
   endtask

   task automatic drive_word(input word_t w, input int unsigned gap);
      repeat (gap)
      begin
         @(posedge clk);
         #2;
         in_valid = 1'b0;
      end
      @(posedge clk);
      #2;
      in_valid = 1'b1;
      in_data  = w;
   endtask

   // insertion keeps exp_q ascending
   task automatic model_insert(input word_t w);
      int pos;
      pos = 0;
      while (pos < exp_q.size() && exp_q[pos] <= w)
      begin
         pos++;
      end
      exp_q.insert(pos, w);
   endtask

   task automatic run_block(input string name, input int unsigned max_gap);
      exp_q.delete();
      for (int i = 0; i < nelems; i++)
      begin
         drive_word(blk[i], $urandom_range(max_gap, 0));
         model_insert(blk[i]);
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      wait_busy(1'b1, 4, name);
      repeat (2) // junk while sorting, must be dropped
      begin
         @(posedge clk);
         #2;
         in_valid = 1'b1;
         in_data  = word_t'($urandom);
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      wait_out_valid(sort_limit, name);
      for (int i = 0; i < nelems; i++)
      begin
         check_value({name, " out_valid"}, 1, int'(out_valid));
         check_value({name, " out_data"}, int'(exp_q[i]), int'(out_data));
         check_value({name, " out_last"}, (i == nelems - 1) ? 1 : 0, int'(out_last));
         @(negedge clk);
      end
      check_value({name, " frame end"}, 0, int'(out_valid));
      wait_busy(1'b0, 8, name);
      check_value({name, " sum_error"}, 0, int'(sum_error));
   endtask

   initial
   begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_data  = '0;
      void'($urandom(32'hc486_206d));
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      blk = '{11'd102, 11'd100, 11'd5, 11'd200, 11'd300};
      run_block("reference", 2);
      blk = '{11'd0, 11'd15, 11'd300, 11'd1024, 11'd2047};
      run_block("sorted", 1);
      blk = '{11'd2047, 11'd1500, 11'd900, 11'd40, 11'd1};
      run_block("reverse", 3);
      blk = '{11'd7, 11'd7, 11'd3, 11'd7, 11'd3};
      run_block("duplicates", 0);
      for (int b = 0; b < 20; b++)
      begin
         for (int i = 0; i < nelems; i++)
         begin
            blk[i] = word_t'($urandom);
         end
         run_block($sformatf("random_%0d", b), 6);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== hw/sort_engine/sort_core.sv ====
module sort_core #(
   parameter int nelems    = 5,
   parameter int word_size = 11
)
(
   input  logic        clk,
   input  logic        rst_n,
   sort_load_if.core   ld,
   sort_read_if.core   rd
);

   localparam int idx_w = sort_pkg::idx_width(nelems);
   localparam logic [idx_w-1:0] last_idx = idx_w'(nelems - 1);

   sort_pkg::core_state_e state;
   sort_pkg::core_state_e state_nxt;

   logic [word_size-1:0] arr      [nelems];
   logic [word_size-1:0] pass_arr [nelems];
   logic [word_size-1:0] pass_tmp;
   logic                 swapped;

   // one full sequential bubble pass, later pairs see earlier swaps
   always_comb
   begin
      pass_arr = arr;
      swapped  = 1'b0;
      pass_tmp = '0;
      for (int i = 0; i < nelems - 1; i++)
      begin
         if (pass_arr[i] > pass_arr[i+1])
         begin
            pass_tmp      = pass_arr[i];
            pass_arr[i]   = pass_arr[i+1];
            pass_arr[i+1] = pass_tmp;
            swapped       = 1'b1;
         end
      end
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         sort_pkg::IDLE:
         begin
            if (ld.wr_en && ld.wr_idx == last_idx)
            begin
               state_nxt = sort_pkg::LOADED;
            end
         end
         sort_pkg::LOADED:
         begin
            if (ld.start)
            begin
               state_nxt = sort_pkg::SORTING;
            end
         end
         sort_pkg::SORTING:
         begin
            if (!swapped) // clean pass, array is in order
            begin
               state_nxt = sort_pkg::DONE;
            end
         end
         sort_pkg::DONE:
         begin
            if (rd.blk_release)
            begin
               state_nxt = sort_pkg::IDLE;
            end
         end
         default:
         begin
            state_nxt = sort_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= sort_pkg::IDLE;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // element storage
   always_ff @(posedge clk)
   begin
      if (state == sort_pkg::IDLE && ld.wr_en)
      begin
         arr[ld.wr_idx] <= ld.wr_data;
      end
      else if (state == sort_pkg::SORTING)
      begin
         arr <= pass_arr;
      end
   end

   assign ld.busy    = (state != sort_pkg::IDLE);
   assign rd.done    = (state == sort_pkg::DONE);
   assign rd.rd_data = arr[rd.rd_idx];

endmodule

// ==== hw/sort_engine/sort_loader.sv ====
module sort_loader #(
   parameter int nelems    = 5,
   parameter int word_size = 11
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  logic [word_size-1:0] in_data,
   output logic [word_size+sort_pkg::sum_guard_bits-1:0] in_sum,
   sort_load_if.loader          ld
);

   localparam int sum_w = sort_pkg::sum_width(word_size);
   localparam int idx_w = sort_pkg::idx_width(nelems);
   localparam logic [idx_w-1:0] last_idx = idx_w'(nelems - 1);

   logic [idx_w-1:0] cnt;
   logic [sum_w-1:0] acc;
   logic             take;
   logic             take_last;

   // words seen while the core is busy are simply dropped
   assign take      = in_valid && !ld.busy;
   assign take_last = take && (cnt == last_idx);

   // each accepted word goes straight into the core at the current index
   assign ld.wr_en   = take;
   assign ld.wr_idx  = cnt;
   assign ld.wr_data = in_data;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt      <= '0;
         acc      <= '0;
         ld.start <= 1'b0;
      end
      else
      begin
         ld.start <= take_last;
         if (take_last)
         begin
            // block complete, count restarts for the next one
            cnt <= '0;
            acc <= '0;
         end
         else if (take)
         begin
            cnt <= cnt + 1'b1;
            acc <= acc + sum_w'(in_data);
         end
      end
   end

   // frozen at the last word, held until the next block completes
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         in_sum <= '0;
      end
      else if (take_last)
      begin
         in_sum <= acc + sum_w'(in_data);
      end
   end

endmodule

// ==== hw/sort_engine/sort_unloader.sv ====
module sort_unloader #(
   parameter int nelems    = 5,
   parameter int word_size = 11
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [word_size+sort_pkg::sum_guard_bits-1:0] in_sum,
   sort_read_if.unloader        rd,
   output logic                 out_valid,
   output logic [word_size-1:0] out_data,
   output logic                 out_last,
   output logic                 sum_error
);

   localparam int sum_w = sort_pkg::sum_width(word_size);
   localparam int idx_w = sort_pkg::idx_width(nelems);
   localparam logic [idx_w-1:0] last_idx = idx_w'(nelems - 1);

   logic             done_q;
   logic             reading;
   logic [idx_w-1:0] idx;
   logic [sum_w-1:0] out_sum;
   logic             rel;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         done_q    <= 1'b0;
         reading   <= 1'b0;
         idx       <= '0;
         out_sum   <= '0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
         sum_error <= 1'b0;
         rel       <= 1'b0;
      end
      else
      begin
         done_q    <= rd.done;
         out_valid <= reading;
         out_last  <= reading && (idx == last_idx);
         rel       <= out_last;
         if (rd.done && !done_q)
         begin
            // first read lands one cycle after done rises
            reading <= 1'b1;
            idx     <= '0;
            out_sum <= '0;
         end
         else if (reading)
         begin
            out_sum <= out_sum + sum_w'(rd.rd_data);
            if (idx == last_idx)
            begin
               reading <= 1'b0;
               idx     <= '0;
            end
            else
            begin
               idx <= idx + 1'b1;
            end
         end
         if (out_last)
         begin
            sum_error <= sum_error | (out_sum != in_sum); // sticky
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reading)
      begin
         out_data <= rd.rd_data;
      end
   end

   assign rd.rd_idx      = idx;
   assign rd.blk_release = rel;

endmodule

// ==== hw/sort_top.sv ====
module sort_top #(
   parameter int nelems    = sort_pkg::default_nelems,
   parameter int word_size = sort_pkg::default_word_size
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid,
   input  logic [word_size-1:0] in_data,
   output logic                 busy,
   output logic                 out_valid,
   output logic [word_size-1:0] out_data,
   output logic                 out_last,
   output logic                 sum_error
);

   localparam int sum_w = sort_pkg::sum_width(word_size);

   logic [sum_w-1:0] in_sum;   // loader to unloader checksum

   sort_load_if #(.nelems(nelems), .word_size(word_size)) ld_if ();
   sort_read_if #(.nelems(nelems), .word_size(word_size)) rd_if ();

   sort_loader #(
      .nelems    (nelems),
      .word_size (word_size)
   ) u_loader (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_data  (in_data),
      .in_sum   (in_sum),
      .ld       (ld_if.loader)
   );

   sort_core #(
      .nelems    (nelems),
      .word_size (word_size)
   ) u_core (
      .clk   (clk),
      .rst_n (rst_n),
      .ld    (ld_if.core),
      .rd    (rd_if.core)
   );

   sort_unloader #(
      .nelems    (nelems),
      .word_size (word_size)
   ) u_unloader (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_sum    (in_sum),
      .rd        (rd_if.unloader),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .sum_error (sum_error)
   );

   assign busy = ld_if.busy;

endmodule
